/* logic/alu_pkg.sv */
package alu_pkg;

  localparam int DATA_W = 64;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [5:0]        flags_t;   // C O A S Z P
  typedef logic [3:0]        op_code_t;
  typedef logic [3:0]        cond_t;
  typedef logic [1:0]        ext_t;

  // bit positions inside flags_t
  localparam int FL_C = 5;
  localparam int FL_O = 4;
  localparam int FL_A = 3;
  localparam int FL_S = 2;
  localparam int FL_Z = 1;
  localparam int FL_P = 0;

  // operation codes, 13..15 give no result
  localparam op_code_t OP_ADD   = 4'd0;
  localparam op_code_t OP_SUB   = 4'd1;
  localparam op_code_t OP_AND   = 4'd2;
  localparam op_code_t OP_OR    = 4'd3;
  localparam op_code_t OP_XOR   = 4'd4;
  localparam op_code_t OP_MOV   = 4'd5;
  localparam op_code_t OP_ZXT8  = 4'd6;
  localparam op_code_t OP_ZXT16 = 4'd7;
  localparam op_code_t OP_SXT8  = 4'd8;
  localparam op_code_t OP_SXT16 = 4'd9;
  localparam op_code_t OP_SXT32 = 4'd10;
  localparam op_code_t OP_CMOV  = 4'd11;
  localparam op_code_t OP_CSET  = 4'd12;

  // condition codes, odd code is the inverse of the one before
  localparam cond_t CC_Z   = 4'd0;
  localparam cond_t CC_NZ  = 4'd1;
  localparam cond_t CC_S   = 4'd2;
  localparam cond_t CC_NS  = 4'd3;
  localparam cond_t CC_UGT = 4'd4;
  localparam cond_t CC_ULE = 4'd5;
  localparam cond_t CC_UGE = 4'd6;
  localparam cond_t CC_ULT = 4'd7;
  localparam cond_t CC_SGT = 4'd8;
  localparam cond_t CC_SLE = 4'd9;
  localparam cond_t CC_SGE = 4'd10;
  localparam cond_t CC_SLT = 4'd11;
  localparam cond_t CC_O   = 4'd12;
  localparam cond_t CC_NO  = 4'd13;
  localparam cond_t CC_P   = 4'd14;
  localparam cond_t CC_NP  = 4'd15;

  // extension source sizes
  localparam ext_t EXT_BYTE = 2'd0;
  localparam ext_t EXT_HALF = 2'd1;
  localparam ext_t EXT_WORD = 2'd2;

  // logic unit function select
  localparam logic [1:0] LS_AND = 2'd0;
  localparam logic [1:0] LS_OR  = 2'd1;
  localparam logic [1:0] LS_XOR = 2'd2;

endpackage

/* logic/op_decode.sv */
`timescale 1ns/1ps

module op_decode (
  input  alu_pkg::op_code_t op,
  input  logic              wide,
  output logic              is_arith,
  output logic              is_sub,
  output logic              is_logic,
  output logic [1:0]        logic_sel,
  output logic              is_mov,
  output logic              is_ext,
  output logic              ext_signed,
  output alu_pkg::ext_t     ext_size,
  output logic              is_cmov,
  output logic              is_cset
);
  import alu_pkg::*;

  always_comb begin
    is_arith   = 1'b0;
    is_sub     = 1'b0;
    is_logic   = 1'b0;
    logic_sel  = LS_AND;
    is_mov     = 1'b0;
    is_ext     = 1'b0;
    ext_signed = 1'b0;
    ext_size   = EXT_BYTE;
    is_cmov    = 1'b0;
    is_cset    = 1'b0;
    case (op)
      OP_ADD: is_arith = 1'b1;
      OP_SUB: begin
        is_arith = 1'b1;
        is_sub   = 1'b1;
      end
      OP_AND: is_logic = 1'b1;
      OP_OR: begin
        is_logic  = 1'b1;
        logic_sel = LS_OR;
      end
      OP_XOR: begin
        is_logic  = 1'b1;
        logic_sel = LS_XOR;
      end
      OP_MOV: is_mov = 1'b1;
      OP_ZXT8: is_ext = 1'b1;
      OP_ZXT16: begin
        is_ext   = 1'b1;
        ext_size = EXT_HALF;
      end
      OP_SXT8: begin
        is_ext     = 1'b1;
        ext_signed = 1'b1;
      end
      OP_SXT16: begin
        is_ext     = 1'b1;
        ext_signed = 1'b1;
        ext_size   = EXT_HALF;
      end
      OP_SXT32: begin
        is_ext     = wide;
        is_mov     = ~wide;   // word into 32 bits is just a move
        ext_signed = 1'b1;
        ext_size   = EXT_WORD;
      end
      OP_CMOV: is_cmov = 1'b1;
      OP_CSET: is_cset = 1'b1;
      default: ;              // no result
    endcase
  end

endmodule

/* logic/add_sub_unit.sv */
`timescale 1ns/1ps

module add_sub_unit (
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  input  logic           is_sub,
  input  logic           wide,
  output alu_pkg::data_t sum,
  output logic           carry,
  output logic           aux_carry,
  output logic           overflow
);
  import alu_pkg::*;

  data_t       b_op;
  logic [64:0] full;
  logic        carry32;
  logic        a_msb;
  logic        b_msb;
  logic        r_msb;

  assign b_op = is_sub ? ~b : b;   // subtract as a + ~b + 1
  assign full = {1'b0, a} + {1'b0, b_op} + {64'b0, is_sub};

  // carry into a bit is the sum bit with both operand bits removed
  assign carry32   = full[32] ^ a[32] ^ b_op[32];
  assign aux_carry = full[4] ^ a[4] ^ b_op[4];
  assign carry     = wide ? full[64] : carry32;

  assign a_msb = wide ? a[63] : a[31];
  assign b_msb = wide ? b_op[63] : b_op[31];
  assign r_msb = wide ? full[63] : full[31];
  assign overflow = (a_msb == b_msb) && (r_msb != a_msb);

  assign sum = wide ? full[63:0] : {32'b0, full[31:0]};

endmodule

/* logic/cond_eval.sv */
`timescale 1ns/1ps

module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            cond_true
);
  import alu_pkg::*;

  logic s_ne_o;

  assign s_ne_o = flags[FL_S] ^ flags[FL_O];

  always_comb begin
    cond_true = 1'b0;
    case (cond)
      CC_Z:   cond_true = flags[FL_Z];
      CC_NZ:  cond_true = ~flags[FL_Z];
      CC_S:   cond_true = flags[FL_S];
      CC_NS:  cond_true = ~flags[FL_S];
      CC_UGT: cond_true = ~(flags[FL_C] | flags[FL_Z]);
      CC_ULE: cond_true = flags[FL_C] | flags[FL_Z];
      CC_UGE: cond_true = ~flags[FL_C];
      CC_ULT: cond_true = flags[FL_C];
      CC_SGT: cond_true = ~(s_ne_o | flags[FL_Z]);
      CC_SLE: cond_true = s_ne_o | flags[FL_Z];
      CC_SGE: cond_true = ~s_ne_o;
      CC_SLT: cond_true = s_ne_o;
      CC_O:   cond_true = flags[FL_O];
      CC_NO:  cond_true = ~flags[FL_O];
      CC_P:   cond_true = flags[FL_P];
      CC_NP:  cond_true = ~flags[FL_P];
      default: ;
    endcase
  end

endmodule

/* logic/logic_move_unit.sv */
`timescale 1ns/1ps

module logic_move_unit #(
  parameter int DATA_W = 64
) (
  input  alu_pkg::data_t a,
  input  alu_pkg::data_t b,
  input  logic           wide,
  input  logic           is_logic,
  input  logic [1:0]     logic_sel,
  input  logic           is_mov,
  input  logic           is_ext,
  input  logic           ext_signed,
  input  alu_pkg::ext_t  ext_size,
  input  logic           is_cmov,
  input  logic           is_cset,
  input  logic           cond_true,
  output alu_pkg::data_t lres
);
  import alu_pkg::*;

  localparam int HALF_W = DATA_W / 2;

  data_t logic_res;
  data_t ext_res;
  data_t full_res;

  always_comb begin
    case (logic_sel)
      LS_OR:   logic_res = a | b;
      LS_XOR:  logic_res = a ^ b;
      default: logic_res = a & b;
    endcase
  end

  // sign or zero fill from the chosen source size
  always_comb begin
    case (ext_size)
      EXT_BYTE: ext_res = {{(DATA_W-8){ext_signed & b[7]}}, b[7:0]};
      EXT_HALF: ext_res = {{(DATA_W-16){ext_signed & b[15]}}, b[15:0]};
      EXT_WORD: ext_res = {{(DATA_W-32){ext_signed & b[31]}}, b[31:0]};
      default:  ext_res = '0;
    endcase
  end

  always_comb begin
    if (is_logic)
      full_res = logic_res;
    else if (is_mov)
      full_res = b;
    else if (is_ext)
      full_res = ext_res;
    else if (is_cmov)
      full_res = cond_true ? b : a;
    else if (is_cset)
      full_res = {{(DATA_W-1){1'b0}}, cond_true};
    else
      full_res = '0;    // no result
  end

  assign lres = wide ? full_res : {{HALF_W{1'b0}}, full_res[HALF_W-1:0]};

endmodule

/* logic/flag_gen.sv */
`timescale 1ns/1ps

module flag_gen (
  input  alu_pkg::data_t  sum,
  input  alu_pkg::data_t  lres,
  input  logic            is_arith,
  input  logic            is_sub,
  input  logic            is_logic,
  input  logic            wide,
  input  logic            carry,
  input  logic            aux_carry,
  input  logic            overflow,
  output alu_pkg::data_t  result,
  output alu_pkg::flags_t fl
);
  import alu_pkg::*;

  logic sign;
  logic zero;
  logic parity;

  assign result = is_arith ? sum : lres;

  assign sign   = wide ? result[63] : result[31];
  assign zero   = wide ? (result == '0) : (result[31:0] == 32'b0);
  assign parity = ~^result[7:0];   // even parity of low byte

  always_comb begin
    fl = '0;
    if (is_arith) begin
      // borrow is the inverted carry on subtract
      fl[FL_C] = carry ^ is_sub;
      fl[FL_O] = overflow;
      fl[FL_A] = aux_carry ^ is_sub;
      fl[FL_S] = sign;
      fl[FL_Z] = zero;
      fl[FL_P] = parity;
    end else if (is_logic) begin
      fl[FL_S] = sign;
      fl[FL_Z] = zero;
      fl[FL_P] = parity;
    end
  end

endmodule

/* logic/alu_retire.sv */
`timescale 1ns/1ps

module alu_retire (
  input  logic            clk,
  input  logic            rst,
  input  logic            valid,
  input  logic            sets_flags,
  input  logic            thread,
  input  logic            except,
  input  logic            except_thread,
  input  alu_pkg::data_t  result,
  input  alu_pkg::flags_t fl,
  output alu_pkg::data_t  res,
  output alu_pkg::flags_t flags,
  output logic            flags_we,
  output logic            ret_en
);

  logic valid_q;
  logic sets_flags_q;
  logic inhibit;
  logic inhibit_q;
  logic except_q;
  logic except_thread_q;

  // same thread hit now or one cycle back
  assign inhibit = (except && (except_thread == thread)) ||
                   (except_q && (except_thread_q == thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q         <= 1'b0;
      sets_flags_q    <= 1'b0;
      inhibit_q       <= 1'b0;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
      res             <= '0;
      flags           <= '0;
    end else begin
      valid_q         <= valid;
      sets_flags_q    <= sets_flags;
      inhibit_q       <= inhibit;
      except_q        <= except;
      except_thread_q <= except_thread;
      res             <= result;
      flags           <= sets_flags ? fl : '0;
    end
  end

  assign ret_en   = valid_q & ~inhibit_q;
  assign flags_we = valid_q & sets_flags_q;

endmodule

/* logic/int_alu.sv */
`timescale 1ns/1ps

module int_alu #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  alu_pkg::op_code_t op,
  input  logic              wide,
  input  alu_pkg::cond_t    cond,
  input  logic              sets_flags,
  input  alu_pkg::flags_t   flags_in,
  input  alu_pkg::data_t    a,
  input  alu_pkg::data_t    b,
  input  logic              thread,
  input  logic              except,
  input  logic              except_thread,
  output alu_pkg::data_t    res,
  output alu_pkg::flags_t   flags,
  output logic              flags_we,
  output logic              ret_en
);
  import alu_pkg::*;

  logic       is_arith;
  logic       is_sub;
  logic       is_logic;
  logic [1:0] logic_sel;
  logic       is_mov;
  logic       is_ext;
  logic       ext_signed;
  ext_t       ext_size;
  logic       is_cmov;
  logic       is_cset;
  logic       cond_true;
  data_t      sum;
  logic       carry;
  logic       aux_carry;
  logic       overflow;
  data_t      lres;
  data_t      result;
  flags_t     fl;

  op_decode u_decode (
    .op(op), .wide(wide), .is_arith(is_arith), .is_sub(is_sub),
    .is_logic(is_logic), .logic_sel(logic_sel), .is_mov(is_mov),
    .is_ext(is_ext), .ext_signed(ext_signed), .ext_size(ext_size),
    .is_cmov(is_cmov), .is_cset(is_cset)
  );

  add_sub_unit u_add (
    .a(a), .b(b), .is_sub(is_sub), .wide(wide), .sum(sum),
    .carry(carry), .aux_carry(aux_carry), .overflow(overflow)
  );

  cond_eval u_cond (.flags(flags_in), .cond(cond), .cond_true(cond_true));

  logic_move_unit #(.DATA_W(DATA_W)) u_lmu (
    .a(a), .b(b), .wide(wide), .is_logic(is_logic), .logic_sel(logic_sel),
    .is_mov(is_mov), .is_ext(is_ext), .ext_signed(ext_signed),
    .ext_size(ext_size), .is_cmov(is_cmov), .is_cset(is_cset),
    .cond_true(cond_true), .lres(lres)
  );

  flag_gen u_flags (
    .sum(sum), .lres(lres), .is_arith(is_arith), .is_sub(is_sub),
    .is_logic(is_logic), .wide(wide), .carry(carry), .aux_carry(aux_carry),
    .overflow(overflow), .result(result), .fl(fl)
  );

  alu_retire u_retire (
    .clk(clk), .rst(rst), .valid(valid), .sets_flags(sets_flags),
    .thread(thread), .except(except), .except_thread(except_thread),
    .result(result), .fl(fl), .res(res), .flags(flags),
    .flags_we(flags_we), .ret_en(ret_en)
  );

endmodule

/* tb/tb_int_alu.sv */
`timescale 1ns/1ps

module tb_int_alu;
  import alu_pkg::*;

  localparam int N_DIR = 140;   // idle, add/sub bounds, op sweep, cond sweep, exceptions
  localparam int N_RAND = 300;
  localparam int N_VEC = N_DIR + N_RAND;

  logic     clk = 1'b0;
  logic     rst;
  logic     valid;
  op_code_t op;
  logic     wide;
  cond_t    cond;
  logic     sets_flags;
  flags_t   flags_in;
  data_t    a;
  data_t    b;
  logic     thread;
  logic     except;
  logic     except_thread;
  data_t    res;
  flags_t   flags;
  logic     flags_we;
  logic     ret_en;

  logic [71:0] exp_q[$];   // {ret_en, flags_we, flags, res}
  logic        prev_ex = 1'b0;
  logic        prev_ext = 1'b0;
  integer      seed = 95;
  int          n_issued = 0;
  int          n_checks = 0;
  int          err_res = 0;
  int          err_flags = 0;
  int          err_we = 0;
  int          err_ret = 0;
  int          err_other = 0;
  data_t       bnd_a [9];
  data_t       bnd_b [9];

  int_alu #(.DATA_W(64)) DUT (
    .clk(clk), .rst(rst), .valid(valid), .op(op), .wide(wide), .cond(cond),
    .sets_flags(sets_flags), .flags_in(flags_in), .a(a), .b(b), .thread(thread),
    .except(except), .except_thread(except_thread), .res(res), .flags(flags),
    .flags_we(flags_we), .ret_en(ret_en)
  );

  always #10 clk = ~clk;

  // returns {flags, res} with flags as C O A S Z P
  function automatic logic [69:0] alu_ref(input op_code_t o, input logic w, input cond_t cc,
                                          input flags_t fin, input data_t x, input data_t y);
    data_t  mask;
    data_t  r;
    flags_t f;
    logic   ct;
    logic   sx;
    logic   sy;
    int     top;
    mask = w ? {64{1'b1}} : 64'h0000_0000_ffff_ffff;
    top  = w ? 63 : 31;
    f    = '0;
    case (cc[3:1])   // even code is the plain test
      0: ct = fin[1];
      1: ct = fin[2];
      2: ct = !(fin[5] | fin[1]);
      3: ct = !fin[5];
      4: ct = !((fin[2] ^ fin[4]) | fin[1]);
      5: ct = (fin[2] == fin[4]);
      6: ct = fin[4];
      default: ct = fin[0];
    endcase
    if (cc[0])
      ct = !ct;
    sx = x[top];
    sy = y[top];
    case (o)
      OP_ADD: begin
        r = (x + y) & mask;
        f[5] = ({1'b0, x & mask} + {1'b0, y & mask}) > {1'b0, mask};
        f[3] = (x[3:0] + y[3:0]) > 15;
        f[4] = (sx == sy) && (r[top] != sx);
      end
      OP_SUB: begin
        r = (x - y) & mask;
        f[5] = (x & mask) < (y & mask);   // borrow
        f[3] = x[3:0] < y[3:0];
        f[4] = (sx != sy) && (r[top] != sx);
      end
      OP_AND:   r = x & y;
      OP_OR:    r = x | y;
      OP_XOR:   r = x ^ y;
      OP_MOV:   r = y;
      OP_ZXT8:  r = {56'b0, y[7:0]};
      OP_ZXT16: r = {48'b0, y[15:0]};
      OP_SXT8:  r = {{56{y[7]}}, y[7:0]};
      OP_SXT16: r = {{48{y[15]}}, y[15:0]};
      OP_SXT32: r = {{32{y[31]}}, y[31:0]};
      OP_CMOV:  r = ct ? y : x;
      OP_CSET:  r = {63'b0, ct};
      default:  r = '0;
    endcase
    r = r & mask;
    if (o == OP_ADD || o == OP_SUB || o == OP_AND || o == OP_OR || o == OP_XOR) begin
      f[2] = r[top];
      f[1] = (r == 0);
      f[0] = ~^r[7:0];
    end
    return {f, r};
  endfunction

  task automatic issue(input logic v, input op_code_t o, input logic w, input cond_t c,
                       input logic sf, input flags_t fi, input data_t x, input data_t y,
                       input logic th, input logic ex, input logic ext);
    logic [69:0] rv;
    logic        e_ret;
    @(posedge clk);
    #2;
    valid = v;
    op = o;
    wide = w;
    cond = c;
    sets_flags = sf;
    flags_in = fi;
    a = x;
    b = y;
    thread = th;
    except = ex;
    except_thread = ext;
    rv = alu_ref(o, w, c, fi, x, y);
    e_ret = v && !(ex && ext == th) && !(prev_ex && prev_ext == th);
    exp_q.push_back({e_ret, v & sf, sf ? rv[69:64] : 6'b0, rv[63:0]});
    prev_ex = ex;
    prev_ext = ext;
    n_issued++;
  endtask

  // compare one cycle after each issue
  initial begin
    logic [71:0] e;
    wait (!rst);
    forever begin
      @(posedge clk);
      #1;
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        n_checks++;
        assert (res === e[63:0]) else begin
          $display("ERR %0t res expected %h actual %h", $time, e[63:0], res);
          err_res++;
        end
        assert (flags === e[69:64]) else begin
          $display("ERR %0t flags expected %b actual %b", $time, e[69:64], flags);
          err_flags++;
        end
        assert (flags_we === e[70]) else begin
          $display("ERR %0t flags_we expected %b actual %b", $time, e[70], flags_we);
          err_we++;
        end
        assert (ret_en === e[71]) else begin
          $display("ERR %0t ret_en expected %b actual %b", $time, e[71], ret_en);
          err_ret++;
        end
      end
    end
  end

  initial begin
    #((N_VEC + 20) * 20);
    $display("timeout, the run did not finish in time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    int          i;
    int          j;
    logic [31:0] rnd;
    data_t       x;
    data_t       y;
    rst = 1'b1;
    valid = 1'b0;
    op = 4'hf;
    wide = 1'b1;
    cond = '0;
    sets_flags = 1'b0;
    flags_in = '0;
    a = '0;
    b = '0;
    thread = 1'b0;
    except = 1'b0;
    except_thread = 1'b0;
    bnd_a = '{64'h0, {64{1'b1}}, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
              64'hffff_ffff, 64'h7fff_ffff, 64'h8000_0000, 64'h0f, 64'h0};
    bnd_b = '{64'h0, 64'h1, 64'h1, 64'h8000_0000_0000_0000,
              64'h1, 64'h1, 64'h1, 64'h1, 64'h1};
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    repeat (2) issue(1'b0, 4'hf, 1'b1, CC_Z, 1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    for (i = 0; i < 9; i++)   // carry and overflow edges
      for (j = 0; j < 4; j++)
        issue(1'b1, j[0] ? OP_SUB : OP_ADD, j[1], CC_Z, 1'b1, '0, bnd_a[i], bnd_b[i],
              1'b0, 1'b0, 1'b0);
    for (i = 0; i < 16; i++)
      for (j = 0; j < 2; j++)
        issue(1'b1, op_code_t'(i), j[0], CC_NZ, 1'b1, 6'b010101,
              64'h8123_4567_89ab_cdef, 64'hfedc_ba98_f654_b2a5, 1'b0, 1'b0, 1'b0);
    for (i = 0; i < 16; i++)
      for (j = 0; j < 4; j++) begin
        rnd = $random(seed);
        issue(1'b1, j[0] ? OP_CSET : OP_CMOV, j[1], cond_t'(i), 1'b1, rnd[5:0],
              {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
              1'b1, 1'b0, 1'b0);
      end
    // same thread now, one back, then the other thread
    issue(1'b1, OP_ADD, 1'b1, CC_Z, 1'b1, '0, 64'h5, 64'h3, 1'b0, 1'b1, 1'b0);
    issue(1'b1, OP_ADD, 1'b1, CC_Z, 1'b1, '0, 64'h6, 64'h3, 1'b0, 1'b0, 1'b0);
    issue(1'b1, OP_ADD, 1'b1, CC_Z, 1'b1, '0, 64'h7, 64'h3, 1'b0, 1'b0, 1'b0);
    issue(1'b1, OP_SUB, 1'b0, CC_Z, 1'b1, '0, 64'h8, 64'h3, 1'b1, 1'b1, 1'b0);
    issue(1'b1, OP_SUB, 1'b0, CC_Z, 1'b1, '0, 64'h9, 64'h3, 1'b0, 1'b0, 1'b0);
    issue(1'b1, OP_SUB, 1'b0, CC_Z, 1'b1, '0, 64'ha, 64'h3, 1'b1, 1'b0, 1'b0);
    for (i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      x = {$random(seed), $random(seed)};
      y = (rnd[31:29] == 0) ? x : {$random(seed), $random(seed)};
      issue(rnd[7:4] != 0, rnd[11:8], rnd[12], rnd[16:13], rnd[17], rnd[23:18], x, y,
            rnd[24], rnd[27:25] == 0, rnd[28]);
    end
    repeat (2) @(posedge clk);
    #5;
    if (n_checks != n_issued) begin
      $display("only %0d of %0d issues were checked", n_checks, n_issued);
      err_other++;
    end
    $display("checks %0d, errors res %0d flags %0d flags_we %0d ret_en %0d other %0d",
             n_checks, err_res, err_flags, err_we, err_ret, err_other);
    if (err_res + err_flags + err_we + err_ret + err_other == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* int_alu.f */
logic/alu_pkg.sv
logic/op_decode.sv
logic/add_sub_unit.sv
logic/cond_eval.sv
logic/logic_move_unit.sv
logic/flag_gen.sv
logic/alu_retire.sv
logic/int_alu.sv
tb/tb_int_alu.sv
